// File: all.f
hdl/isa_pkg.sv
hdl/cpu_types_pkg.sv
hdl/regfile_if.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/reg_file.sv
hdl/writeback.sv
hdl/cpu_top.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

// File: hdl/cpu_top.sv
module cpu_top
    import cpu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    output logic       icache_req,
    output u32_t       icache_pa,
    input  logic       icache_busy,
    input  u32_t       icache_data,
    input  logic       icache_data_valid,

    output u32_t       debug0_wb_pc,
    output logic [3:0] debug0_wb_rf_wen,
    output reg_idx_t   debug0_wb_rf_wnum,
    output u32_t       debug0_wb_rf_wdata,
    output u32_t       debug0_wb_inst
);

    fetch_decode_pass_t   pass_if;
    decode_execute_pass_t pass_id;
    execute_wb_pass_t     pass_ex;

    logic     redirect_valid;
    u32_t     redirect_pc;
    forward_t ex_fwd;
    forward_t wb_fwd;

    regfile_if rf_bus ();

    fetch u_fetch (
        .clk,
        .rst_n,
        .icache_req,
        .icache_pa,
        .icache_busy,
        .icache_data,
        .icache_data_valid,
        .redirect_valid,
        .redirect_pc,
        .pass_out (pass_if)
    );

    // a taken branch in execute also kills the instruction in decode
    decode u_decode (
        .clk,
        .rst_n,
        .pass_in  (pass_if),
        .flush    (redirect_valid),
        .rf       (rf_bus.reader),
        .ex_fwd,
        .wb_fwd,
        .pass_out (pass_id)
    );

    execute u_execute (
        .clk,
        .rst_n,
        .pass_in  (pass_id),
        .redirect_valid,
        .redirect_pc,
        .fwd      (ex_fwd),
        .pass_out (pass_ex)
    );

    writeback u_writeback (
        .clk,
        .rst_n,
        .pass_in  (pass_ex),
        .rf       (rf_bus.writer),
        .fwd      (wb_fwd),
        .debug0_wb_pc,
        .debug0_wb_rf_wen,
        .debug0_wb_rf_wnum,
        .debug0_wb_rf_wdata,
        .debug0_wb_inst
    );

    reg_file u_reg_file (
        .clk,
        .rst_n,
        .rf (rf_bus.regs)
    );

endmodule

// File: hdl/cpu_types_pkg.sv
package cpu_types_pkg;

    import isa_pkg::*;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;

    localparam u32_t RESET_PC = 32'h1c00_0000;

    typedef struct packed {
        logic valid;
        u32_t pc;
        u32_t inst;
    } fetch_decode_pass_t;

    // the raw word rides along so writeback can put it on the trace
    typedef struct packed {
        logic     valid;
        u32_t     pc;
        u32_t     inst;
        alu_op_t  alu_op;
        u32_t     src_a;
        u32_t     src_b;
        logic     is_branch;
        logic     branch_ne;
        u32_t     branch_target;
        reg_idx_t rd;
        logic     wen;
    } decode_execute_pass_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        u32_t     inst;
        reg_idx_t rd;
        logic     wen;
        u32_t     result;
    } execute_wb_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t idx;
        u32_t     data;
    } forward_t;

endpackage

// File: hdl/decode.sv
module decode
    import isa_pkg::*;
    import cpu_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  fetch_decode_pass_t   pass_in,
    input  logic                 flush,

    regfile_if.reader            rf,

    input  forward_t             ex_fwd,
    input  forward_t             wb_fwd,

    output decode_execute_pass_t pass_out
);

    inst_word_t           iw;
    logic                 is_r3;
    logic                 is_addi;
    logic                 is_br;
    alu_op_t              r3_op;
    u32_t                 imm_sext;
    u32_t                 offs_sext;
    u32_t                 rj_val;
    u32_t                 rkd_val;
    decode_execute_pass_t dec;

    function automatic logic fwd_hit(forward_t f, reg_idx_t idx);
        return f.valid && (f.idx == idx) && (idx != '0);
    endfunction

    // the younger result in execute wins over the one in writeback
    function automatic u32_t pick_operand(reg_idx_t idx, u32_t rf_data,
                                          forward_t ex, forward_t wb);
        if (fwd_hit(ex, idx)) begin
            return ex.data;
        end
        if (fwd_hit(wb, idx)) begin
            return wb.data;
        end
        return rf_data;
    endfunction

    assign iw = pass_in.inst;

    always_comb begin
        is_r3 = 1'b1;
        r3_op = ALU_PASS;
        case (iw.r3.opcode)
            OP_ADD_W: r3_op = ALU_ADD;
            OP_SUB_W: r3_op = ALU_SUB;
            OP_AND:   r3_op = ALU_AND;
            OP_OR:    r3_op = ALU_OR;
            OP_XOR:   r3_op = ALU_XOR;
            default:  is_r3 = 1'b0;
        endcase
    end

    assign is_addi   = iw.ri12.opcode == OP_ADDI_W;
    assign is_br     = (iw.ri16.opcode == OP_BEQ) || (iw.ri16.opcode == OP_BNE);
    assign imm_sext  = {{20{iw.ri12.imm[11]}}, iw.ri12.imm};
    assign offs_sext = {{14{iw.ri16.offs[15]}}, iw.ri16.offs, 2'b00};

    // branches compare rj with rd, so the second port reads rd for them
    assign rf.rj  = iw.r3.rj;
    assign rf.rkd = is_br ? iw.ri16.rd : iw.r3.rk;

    assign rj_val  = pick_operand(rf.rj, rf.rj_data, ex_fwd, wb_fwd);
    assign rkd_val = pick_operand(rf.rkd, rf.rkd_data, ex_fwd, wb_fwd);

    always_comb begin
        dec.valid         = pass_in.valid && !flush;
        dec.pc            = pass_in.pc;
        dec.inst          = pass_in.inst;
        dec.alu_op        = is_addi ? ALU_ADD : r3_op;
        dec.src_a         = rj_val;
        dec.src_b         = is_addi ? imm_sext : rkd_val;
        dec.is_branch     = is_br;
        dec.branch_ne     = iw.ri16.opcode == OP_BNE;
        dec.branch_target = pass_in.pc + offs_sext;
        dec.rd            = iw.r3.rd;
        dec.wen           = (is_r3 || is_addi) && (iw.r3.rd != '0);
    end

    always_ff @(posedge clk) begin
        pass_out <= dec;
        if (!rst_n) begin
            pass_out.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/execute.sv
module execute
    import isa_pkg::*;
    import cpu_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  decode_execute_pass_t pass_in,

    output logic                 redirect_valid,
    output u32_t                 redirect_pc,

    output forward_t             fwd,

    output execute_wb_pass_t     pass_out
);

    u32_t             result;
    logic             operands_eq;
    logic             taken;
    execute_wb_pass_t nxt;

    always_comb begin
        case (pass_in.alu_op)
            ALU_ADD:  result = pass_in.src_a + pass_in.src_b;
            ALU_SUB:  result = pass_in.src_a - pass_in.src_b;
            ALU_AND:  result = pass_in.src_a & pass_in.src_b;
            ALU_OR:   result = pass_in.src_a | pass_in.src_b;
            ALU_XOR:  result = pass_in.src_a ^ pass_in.src_b;
            ALU_PASS: result = pass_in.src_b;
            default:  result = '0;
        endcase
    end

    assign operands_eq = pass_in.src_a == pass_in.src_b;

    // BNE takes the branch on inequality, BEQ on equality
    assign taken = pass_in.valid && pass_in.is_branch
                   && (pass_in.branch_ne ? !operands_eq : operands_eq);

    assign redirect_valid = taken;
    assign redirect_pc    = pass_in.branch_target;

    assign fwd.valid = pass_in.valid && pass_in.wen;
    assign fwd.idx   = pass_in.rd;
    assign fwd.data  = result;

    // branches already carry wen low from decode
    always_comb begin
        nxt.valid  = pass_in.valid;
        nxt.pc     = pass_in.pc;
        nxt.inst   = pass_in.inst;
        nxt.rd     = pass_in.rd;
        nxt.wen    = pass_in.wen;
        nxt.result = result;
    end

    always_ff @(posedge clk) begin
        pass_out <= nxt;
        if (!rst_n) begin
            pass_out.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/fetch.sv
module fetch
    import cpu_types_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,

    output logic               icache_req,
    output u32_t               icache_pa,
    input  logic               icache_busy,
    input  u32_t               icache_data,
    input  logic               icache_data_valid,

    input  logic               redirect_valid,
    input  u32_t               redirect_pc,

    output fetch_decode_pass_t pass_out
);

    u32_t pc;
    u32_t req_pc;
    logic running;
    logic outstanding;
    logic drop;

    // an answer arriving this cycle frees the port for the next request
    assign icache_req = running && !icache_busy && !redirect_valid
                        && (!outstanding || icache_data_valid);
    assign icache_pa  = pc;

    always_ff @(posedge clk) begin
        if (icache_req) begin
            req_pc <= pc;
        end
        if (icache_data_valid) begin
            pass_out.pc   <= req_pc;
            pass_out.inst <= icache_data;
        end

        if (!rst_n) begin
            pc             <= RESET_PC;
            running        <= 1'b0;
            outstanding    <= 1'b0;
            drop           <= 1'b0;
            pass_out.valid <= 1'b0;
        end else begin
            running <= 1'b1;

            if (icache_req) begin
                outstanding <= 1'b1;
            end else if (icache_data_valid) begin
                outstanding <= 1'b0;
            end

            if (redirect_valid) begin
                // whatever is still in flight belongs to the wrong path
                pc             <= redirect_pc;
                drop           <= outstanding && !icache_data_valid;
                pass_out.valid <= 1'b0;
            end else begin
                if (icache_req) begin
                    pc <= pc + 32'd4;
                end
                if (icache_data_valid) begin
                    drop <= 1'b0;
                end
                pass_out.valid <= icache_data_valid && !drop;
            end
        end
    end

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

    // three-register format, used by the integer ALU ops
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_fmt_t;

    // branches compare rj with rd and jump by offs words
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri16_fmt_t;

    typedef union packed {
        r3_fmt_t   r3;
        ri12_fmt_t ri12;
        ri16_fmt_t ri16;
    } inst_word_t;

    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [5:0]  OP_BEQ    = 6'h16;
    localparam logic [5:0]  OP_BNE    = 6'h17;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS
    } alu_op_t;

endpackage

// File: hdl/reg_file.sv
module reg_file
    import cpu_types_pkg::*;
(
    input logic    clk,
    input logic    rst_n,

    regfile_if.regs rf
);

    u32_t regs [32];

    assign rf.rj_data  = regs[rf.rj];
    assign rf.rkd_data = regs[rf.rkd];

    // r0 is cleared on reset and never written afterwards
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (rf.we && (rf.rd != '0)) begin
            regs[rf.rd] <= rf.rd_data;
        end
    end

endmodule

// File: hdl/regfile_if.sv
interface regfile_if
    import cpu_types_pkg::*;
();

    reg_idx_t rj;
    reg_idx_t rkd;
    u32_t     rj_data;
    u32_t     rkd_data;
    logic     we;
    reg_idx_t rd;
    u32_t     rd_data;

    // read data comes back in the same cycle as the index
    modport reader (output rj, rkd, input rj_data, rkd_data);
    modport writer (output we, rd, rd_data);
    modport regs (input rj, rkd, we, rd, rd_data, output rj_data, rkd_data);

endinterface

// File: hdl/writeback.sv
module writeback
    import cpu_types_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    input  execute_wb_pass_t pass_in,

    regfile_if.writer        rf,

    output forward_t         fwd,

    output u32_t             debug0_wb_pc,
    output logic [3:0]       debug0_wb_rf_wen,
    output reg_idx_t         debug0_wb_rf_wnum,
    output u32_t             debug0_wb_rf_wdata,
    output u32_t             debug0_wb_inst
);

    logic we;

    assign we = pass_in.valid && pass_in.wen;

    assign rf.we      = we;
    assign rf.rd      = pass_in.rd;
    assign rf.rd_data = pass_in.result;

    // the register file only sees this value after the edge
    assign fwd.valid = we;
    assign fwd.idx   = pass_in.rd;
    assign fwd.data  = pass_in.result;

    always_ff @(posedge clk) begin
        debug0_wb_rf_wnum  <= pass_in.rd;
        debug0_wb_rf_wdata <= pass_in.result;
        debug0_wb_inst     <= pass_in.inst;
        if (!rst_n) begin
            debug0_wb_pc     <= '0;
            debug0_wb_rf_wen <= '0;
        end else begin
            debug0_wb_pc     <= pass_in.valid ? pass_in.pc : '0;
            debug0_wb_rf_wen <= {4{we}};
        end
    end

endmodule

// File: verif/cpu_properties.sv
module cpu_properties
    import cpu_types_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       icache_req,
    input logic       icache_busy,
    input logic       icache_data_valid,
    input logic [3:0] debug0_wb_rf_wen,
    input reg_idx_t   debug0_wb_rf_wnum
);

    int   failures = 0;
    logic waiting;

    // set by a request and cleared by the answer that follows it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            waiting <= 1'b0;
        end else if (icache_req) begin
            waiting <= 1'b1;
        end else if (icache_data_valid) begin
            waiting <= 1'b0;
        end
    end

    no_req_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req |-> !icache_busy)
        else begin
            $error("icache_req raised while icache_busy is high");
            failures++;
        end

    // the cycle that carries the answer already frees the port
    one_request_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        icache_req |-> (!waiting || icache_data_valid))
        else begin
            $error("icache_req raised while an earlier answer is still outstanding");
            failures++;
        end

    wen_all_or_none: assert property (@(posedge clk) disable iff (!rst_n)
        (debug0_wb_rf_wen == 4'h0) || (debug0_wb_rf_wen == 4'hf))
        else begin
            $error("debug0_wb_rf_wen is neither zero nor all ones");
            failures++;
        end

    no_trace_write_to_r0: assert property (@(posedge clk) disable iff (!rst_n)
        (debug0_wb_rf_wen != 4'h0) |-> (debug0_wb_rf_wnum != '0))
        else begin
            $error("trace shows a register write to r0");
            failures++;
        end

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !icache_req)
        else begin
            $error("icache_req is high in the cycle after reset");
            failures++;
        end

endmodule

bind cpu_top cpu_properties u_properties (
    .clk,
    .rst_n,
    .icache_req,
    .icache_busy,
    .icache_data_valid,
    .debug0_wb_rf_wen,
    .debug0_wb_rf_wnum
);

// File: verif/cpu_tb.sv
module cpu_tb
    import isa_pkg::*;
    import cpu_types_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_INST = 40;
    localparam int IMEM_WORDS      = 128;
    localparam int NUM_TESTS       = 5;

    logic       clk;
    logic       rst_n;
    logic       icache_req;
    u32_t       icache_pa;
    logic       icache_busy;
    u32_t       icache_data;
    logic       icache_data_valid;
    u32_t       debug0_wb_pc;
    logic [3:0] debug0_wb_rf_wen;
    reg_idx_t   debug0_wb_rf_wnum;
    u32_t       debug0_wb_rf_wdata;
    u32_t       debug0_wb_inst;

    u32_t  imem [IMEM_WORDS];
    u32_t  program_words [$];
    int    prog_first [NUM_TESTS];
    int    prog_len [NUM_TESTS];
    string prog_name [NUM_TESTS];
    int    num_progs;

    u32_t  model_pc;
    u32_t  model_regs [32];
    u32_t  end_pc;
    logic  checking;
    logic  test_done;
    int    check_count;
    int    error_count;
    int    cycle_count;
    int    cycle_limit;

    cpu_top i_cpu_top (
        .clk,
        .rst_n,
        .icache_req,
        .icache_pa,
        .icache_busy,
        .icache_data,
        .icache_data_valid,
        .debug0_wb_pc,
        .debug0_wb_rf_wen,
        .debug0_wb_rf_wnum,
        .debug0_wb_rf_wdata,
        .debug0_wb_inst
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    function automatic u32_t r3_word(logic [16:0] op, reg_idx_t rd, reg_idx_t rj,
                                     reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic u32_t addi_word(reg_idx_t rd, reg_idx_t rj, logic [11:0] imm);
        return {OP_ADDI_W, imm, rj, rd};
    endfunction

    function automatic u32_t branch_word(logic [5:0] op, reg_idx_t rj, reg_idx_t rd,
                                         logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    // top six bits all ones, so no view decodes it and the core treats it as a no-op
    function automatic u32_t fill_word(u32_t addr);
        return {6'h3f, addr[27:2] ^ addr[31:6]};
    endfunction

    function automatic u32_t imem_read(u32_t addr);
        u32_t idx;
        idx = (addr - RESET_PC) >> 2;
        if ((addr[1:0] == 2'b00) && (idx < IMEM_WORDS)) begin
            return imem[idx];
        end
        return fill_word(addr);
    endfunction

    function automatic void model_step(inout u32_t pc, inout u32_t regs [32],
                                       output u32_t exp_pc, output reg_idx_t wnum,
                                       output u32_t wdata, output logic wen);
        inst_word_t w;
        u32_t       a;
        u32_t       b;
        u32_t       next_pc;
        w       = imem_read(pc);
        exp_pc  = pc;
        next_pc = pc + 32'd4;
        wnum    = w.r3.rd;
        wdata   = '0;
        wen     = 1'b0;
        a       = regs[w.r3.rj];
        b       = regs[w.r3.rk];
        if ((w.ri16.opcode == OP_BEQ) || (w.ri16.opcode == OP_BNE)) begin
            // a branch finds its second operand in the rd field
            b = regs[w.ri16.rd];
            if ((a == b) == (w.ri16.opcode == OP_BEQ)) begin
                next_pc = pc + {{14{w.ri16.offs[15]}}, w.ri16.offs, 2'b00};
            end
        end else if (w.ri12.opcode == OP_ADDI_W) begin
            wen   = 1'b1;
            wdata = a + {{20{w.ri12.imm[11]}}, w.ri12.imm};
        end else begin
            wen = 1'b1;
            case (w.r3.opcode)
                OP_ADD_W: wdata = a + b;
                OP_SUB_W: wdata = a - b;
                OP_AND:   wdata = a & b;
                OP_OR:    wdata = a | b;
                OP_XOR:   wdata = a ^ b;
                default:  wen = 1'b0;
            endcase
        end
        if (wnum == '0) begin
            wen = 1'b0;
        end
        if (wen) begin
            regs[wnum] = wdata;
        end
        pc = next_pc;
    endfunction

    // branches only jump forward, so a random program always reaches its end
    function automatic u32_t random_word(int idx, int last);
        int       kind;
        int       offs;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        kind = $urandom % 8;
        rd   = reg_idx_t'($urandom % 8);
        rj   = reg_idx_t'($urandom % 8);
        rk   = reg_idx_t'($urandom % 8);
        offs = 1 + $urandom % 3;
        if (idx + offs > last) begin
            offs = last - idx;
        end
        case (kind)
            0:       return r3_word(OP_ADD_W, rd, rj, rk);
            1:       return r3_word(OP_SUB_W, rd, rj, rk);
            2:       return r3_word(OP_AND, rd, rj, rk);
            3:       return r3_word(OP_OR, rd, rj, rk);
            4:       return r3_word(OP_XOR, rd, rj, rk);
            5, 6:    return addi_word(rd, rj, 12'($urandom));
            default: return branch_word(($urandom % 2) ? OP_BNE : OP_BEQ, rj, rd, 16'(offs));
        endcase
    endfunction

    task automatic check_value(string name, u32_t actual, u32_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h at time %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic start_program(string name);
        prog_name[num_progs]  = name;
        prog_first[num_progs] = program_words.size();
    endtask

    task automatic emit(u32_t word);
        program_words.push_back(word);
    endtask

    // every program ends in a branch to itself
    task automatic finish_program();
        emit(branch_word(OP_BEQ, 5'd0, 5'd0, 16'h0000));
        prog_len[num_progs] = program_words.size() - prog_first[num_progs];
        num_progs++;
    endtask

    task automatic build_programs();
        start_program("dependent ALU chain");
        emit(addi_word(5'd1, 5'd0, 12'h123));
        emit(addi_word(5'd2, 5'd0, 12'h05a));
        emit(r3_word(OP_ADD_W, 5'd3, 5'd1, 5'd2));
        emit(r3_word(OP_SUB_W, 5'd4, 5'd3, 5'd1));
        emit(r3_word(OP_AND, 5'd5, 5'd4, 5'd3));
        emit(r3_word(OP_OR, 5'd6, 5'd5, 5'd1));
        emit(r3_word(OP_XOR, 5'd7, 5'd6, 5'd4));
        emit(r3_word(OP_ADD_W, 5'd7, 5'd7, 5'd7));
        emit(r3_word(OP_SUB_W, 5'd8, 5'd2, 5'd7));
        emit(r3_word(OP_XOR, 5'd9, 5'd8, 5'd3));
        finish_program();

        start_program("ADDI.W sign extension");
        emit(addi_word(5'd1, 5'd0, 12'hfff));
        emit(addi_word(5'd2, 5'd1, 12'h800));
        emit(addi_word(5'd3, 5'd0, 12'h7ff));
        emit(addi_word(5'd4, 5'd3, 12'h801));
        emit(addi_word(5'd5, 5'd2, 12'h001));
        emit(addi_word(5'd6, 5'd5, 12'hf00));
        finish_program();

        // r10, r11 and r12 get marker values only on the wrong path
        start_program("BEQ and BNE");
        emit(addi_word(5'd1, 5'd0, 12'h005));
        emit(addi_word(5'd2, 5'd0, 12'h005));
        emit(branch_word(OP_BEQ, 5'd1, 5'd2, 16'd3));
        emit(addi_word(5'd10, 5'd0, 12'h7aa));
        emit(addi_word(5'd11, 5'd0, 12'h7bb));
        emit(branch_word(OP_BNE, 5'd1, 5'd2, 16'd3));
        emit(addi_word(5'd3, 5'd0, 12'h001));
        emit(branch_word(OP_BNE, 5'd1, 5'd3, 16'd2));
        emit(addi_word(5'd12, 5'd0, 12'h7cc));
        emit(branch_word(OP_BEQ, 5'd1, 5'd3, 16'd2));
        emit(addi_word(5'd5, 5'd0, 12'h003));
        emit(addi_word(5'd5, 5'd5, 12'hfff));
        emit(branch_word(OP_BNE, 5'd5, 5'd0, 16'hffff));
        emit(r3_word(OP_ADD_W, 5'd4, 5'd10, 5'd12));
        finish_program();

        start_program("writes to r0");
        emit(addi_word(5'd0, 5'd0, 12'h055));
        emit(addi_word(5'd1, 5'd0, 12'h007));
        emit(r3_word(OP_ADD_W, 5'd0, 5'd1, 5'd1));
        emit(r3_word(OP_OR, 5'd2, 5'd0, 5'd0));
        emit(r3_word(OP_ADD_W, 5'd0, 5'd1, 5'd1));
        emit(r3_word(OP_ADD_W, 5'd3, 5'd0, 5'd1));
        emit(r3_word(OP_SUB_W, 5'd4, 5'd0, 5'd1));
        finish_program();

        start_program("random program");
        for (int i = 0; i < 60; i++) begin
            emit(random_word(i, 60));
        end
        finish_program();
    endtask

    task automatic load_program(int t);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = fill_word(RESET_PC + 32'(4 * i));
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            imem[i] = program_words[prog_first[t] + i];
        end
        end_pc = RESET_PC + 32'(4 * (prog_len[t] - 1));
    endtask

    task automatic run_test(int t);
        load_program(t);
        model_pc  = RESET_PC;
        test_done = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        checking = 1'b1;
        rst_n    = 1'b1;
        wait (test_done);
    endtask

    // answers each request after 1 to 4 cycles, with random busy cycles meanwhile
    initial begin : icache_model
        logic req_seen;
        u32_t pa_seen;
        logic pending;
        u32_t pending_pa;
        int   delay;
        pending    = 1'b0;
        pending_pa = '0;
        delay      = 0;
        forever begin
            @(negedge clk);
            req_seen = icache_req === 1'b1;
            pa_seen  = icache_pa;
            @(posedge clk);
            #1;
            icache_data_valid = 1'b0;
            if (req_seen) begin
                pending    = 1'b1;
                pending_pa = pa_seen;
                delay      = $urandom % 4;
            end
            if (pending && (delay == 0)) begin
                icache_data_valid = 1'b1;
                icache_data       = imem_read(pending_pa);
                pending           = 1'b0;
            end else if (pending) begin
                delay--;
            end
            icache_busy = (pending || icache_data_valid) && (($urandom % 3) == 0);
        end
    end

    always @(negedge clk) begin : compare_trace
        u32_t     exp_pc;
        reg_idx_t exp_wnum;
        u32_t     exp_wdata;
        logic     exp_wen;
        if (checking && (debug0_wb_pc != '0)) begin
            model_step(model_pc, model_regs, exp_pc, exp_wnum, exp_wdata, exp_wen);
            check_value("debug0_wb_pc", debug0_wb_pc, exp_pc);
            check_value("debug0_wb_inst", debug0_wb_inst, imem_read(exp_pc));
            check_value("debug0_wb_rf_wen", 32'(debug0_wb_rf_wen), exp_wen ? 32'hf : 32'h0);
            if (exp_wen) begin
                check_value("debug0_wb_rf_wnum", 32'(debug0_wb_rf_wnum), 32'(exp_wnum));
                check_value("debug0_wb_rf_wdata", debug0_wb_rf_wdata, exp_wdata);
            end
            if (exp_pc == end_pc) begin
                checking  = 1'b0;
                test_done = 1'b1;
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: a program did not reach its final branch within %0d cycles",
                 cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        int tests_passed;
        int errors_before;
        int asserts_before;
        int total_insts;
        rst_n             = 1'b0;
        icache_busy       = 1'b0;
        icache_data       = '0;
        icache_data_valid = 1'b0;
        checking          = 1'b0;
        test_done         = 1'b0;
        check_count       = 0;
        error_count       = 0;
        cycle_limit       = 0;
        num_progs         = 0;
        tests_passed      = 0;
        total_insts       = 0;
        void'($urandom(32'h85a4_1493));
        build_programs();
        for (int t = 0; t < num_progs; t++) begin
            total_insts += prog_len[t];
        end
        cycle_limit = CYCLES_PER_INST * total_insts;

        for (int t = 0; t < num_progs; t++) begin
            errors_before  = error_count;
            asserts_before = i_cpu_top.u_properties.failures;
            run_test(t);
            if ((error_count == errors_before)
                    && (i_cpu_top.u_properties.failures == asserts_before)) begin
                tests_passed++;
                $display("test %0d, %s: pass", t + 1, prog_name[t]);
            end else begin
                $display("test %0d, %s: mismatches found", t + 1, prog_name[t]);
            end
        end

        $display("%0d of %0d tests passed, %0d checks, %0d check errors, %0d assertion errors",
                 tests_passed, num_progs, check_count, error_count,
                 i_cpu_top.u_properties.failures);
        if ((error_count == 0) && (i_cpu_top.u_properties.failures == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
